// File: mips_cpu_bus.f
+incdir+source
source/mips_pkg.sv
source/mips_control.sv
source/mips_register_file.sv
source/mips_alu.sv
source/mips_pc_unit.sv
source/mips_load_store.sv
source/mips_cpu_bus.sv
test/avalon_mem_model.sv
test/tb_mips_cpu_bus.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary -j 0 --top-module tb_mips_cpu_bus -f mips_cpu_bus.f -Mdir obj_dir
	-./obj_dir/Vtb_mips_cpu_bus > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" sim.log; then echo "test did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: test/tb_mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module tb_mips_cpu_bus import mips_pkg::*; ();

  logic       clk;
  logic       reset;
  logic       random_stalls;
  logic       active;
  word_t      register_v0;
  word_t      address;
  logic       write;
  logic       read;
  logic       waitrequest;
  word_t      writedata;
  logic [3:0] byteenable;
  word_t      readdata;

  word_t prog [256];
  int    prog_len;
  word_t ref_data [64];
  word_t zero_wait_v0;

  mips_cpu_bus mips_cpu_bus_i (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .register_v0 (register_v0),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata)
  );

  avalon_mem_model mem_i (
    .clk           (clk),
    .random_stalls (random_stalls),
    .address       (address),
    .read          (read),
    .write         (write),
    .writedata     (writedata),
    .byteenable    (byteenable),
    .readdata      (readdata),
    .waitrequest   (waitrequest)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  function automatic word_t rtype(input logic [5:0] fn, input int rs, input int rt,
                                  input int rd, input int sh);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t itype(input logic [5:0] op, input int rs, input int rt,
                                  input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t jtype(input logic [5:0] op, input word_t target);
    return {op, target[27:2]};
  endfunction

  // address of instruction slot n in the code window
  function automatic word_t slot_addr(input int n);
    return `MIPS_RESET_VECTOR + 32'(n * 4);
  endfunction

  function automatic word_t fill_word(input word_t addr);
    return addr ^ 32'hC3A5_0F1E;
  endfunction

  task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  function automatic word_t data_read(input word_t addr);
    word_t off;
    off = addr - 32'h1000;
    if (off < 32'd256) begin
      return ref_data[off[7:2]];
    end
    return '0;
  endfunction

  function automatic void data_write(input word_t addr, input word_t data,
                                     input logic [3:0] lanes);
    word_t off;
    off = addr - 32'h1000;
    if (off < 32'd256) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          ref_data[off[7:2]][i*8 +: 8] = data[i*8 +: 8];
        end
      end
    end
  endfunction

  // instruction-set model of the subset, returns v0 and leaves ref_data
  function automatic word_t run_reference();
    word_t      regs [32];
    word_t      pc, instr, a, b, simm, zimm, res, addr, target, dtarget, off, next;
    logic       pending, taken, wr;
    logic [7:0] mem_byte;
    reg_idx_t   dest;
    int         steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) ref_data[i] = fill_word(32'h1000 + 32'(i * 4));
    pc = `MIPS_RESET_VECTOR;
    pending = 1'b0;
    dtarget = '0;
    steps = 0;
    while (pc != 32'd0 && steps < 4000) begin
      off = pc - `MIPS_RESET_VECTOR;
      instr = (off < 32'd1024) ? prog[off[9:2]] : 32'd0;
      a = regs[instr[25:21]];
      b = regs[instr[20:16]];
      simm = {{16{instr[15]}}, instr[15:0]};
      zimm = {16'h0000, instr[15:0]};
      addr = a + simm;
      mem_byte = 8'(data_read(addr) >> (8 * addr[1:0]));
      taken = 1'b0;
      target = '0;
      wr = 1'b1;
      dest = instr[20:16];
      res = '0;
      case (instr[31:26])
        `MIPS_OP_SPECIAL: begin
          dest = instr[15:11];
          case (instr[5:0])
            `MIPS_FN_ADDU: res = a + b;
            `MIPS_FN_SUBU: res = a - b;
            `MIPS_FN_AND:  res = a & b;
            `MIPS_FN_OR:   res = a | b;
            `MIPS_FN_XOR:  res = a ^ b;
            `MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `MIPS_FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            `MIPS_FN_SLL:  res = b << instr[10:6];
            `MIPS_FN_SRL:  res = b >> instr[10:6];
            `MIPS_FN_SRA:  res = word_t'($signed(b) >>> instr[10:6]);
            `MIPS_FN_JR: begin
              wr = 1'b0;
              taken = 1'b1;
              target = a;
            end
            default: wr = 1'b0;
          endcase
        end
        `MIPS_OP_ADDIU: res = a + simm;
        `MIPS_OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
        `MIPS_OP_ANDI:  res = a & zimm;
        `MIPS_OP_ORI:   res = a | zimm;
        `MIPS_OP_XORI:  res = a ^ zimm;
        `MIPS_OP_LUI:   res = {instr[15:0], 16'h0000};
        `MIPS_OP_LW:    res = data_read(addr);
        `MIPS_OP_LB:    res = {{24{mem_byte[7]}}, mem_byte};
        `MIPS_OP_LBU:   res = {24'd0, mem_byte};
        `MIPS_OP_SW: begin
          wr = 1'b0;
          data_write(addr, b, 4'b1111);
        end
        `MIPS_OP_SB: begin
          wr = 1'b0;
          data_write(addr, {4{b[7:0]}}, 4'b0001 << addr[1:0]);
        end
        `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
          wr = 1'b0;
          taken = (a == b) ^ (instr[31:26] == `MIPS_OP_BNE);
          target = pc + 32'd4 + {simm[29:0], 2'b00};
        end
        `MIPS_OP_J, `MIPS_OP_JAL: begin
          wr = (instr[31:26] == `MIPS_OP_JAL);
          dest = 5'd31;
          res = pc + 32'd8;
          taken = 1'b1;
          target = {next_word_top(pc), instr[25:0], 2'b00};
        end
        default: wr = 1'b0;
      endcase
      if (wr && dest != 5'd0) regs[dest] = res;
      next = pending ? dtarget : pc + 32'd4;
      if (taken) dtarget = target;
      pending = taken;
      pc = next;
      steps++;
    end
    return regs[2];
  endfunction

  function automatic logic [3:0] next_word_top(input word_t pc);
    word_t p4;
    p4 = pc + 32'd4;
    return p4[31:28];
  endfunction

  task automatic build_alu_program();
    prog_len = 0;
    emit(itype(`MIPS_OP_ADDIU, 0, 8, 16'h1234));
    emit(itype(`MIPS_OP_LUI, 0, 9, 16'h8000));
    emit(itype(`MIPS_OP_ORI, 9, 9, 16'h0F0F));
    emit(rtype(`MIPS_FN_ADDU, 8, 9, 10, 0));
    emit(rtype(`MIPS_FN_SUBU, 8, 9, 11, 0));
    emit(rtype(`MIPS_FN_AND, 10, 11, 12, 0));
    emit(rtype(`MIPS_FN_OR, 12, 8, 13, 0));
    emit(rtype(`MIPS_FN_XOR, 13, 8, 14, 0));
    emit(rtype(`MIPS_FN_SLL, 0, 9, 15, 4));
    emit(rtype(`MIPS_FN_SRL, 0, 9, 16, 3));
    emit(rtype(`MIPS_FN_SRA, 0, 9, 17, 5));
    emit(rtype(`MIPS_FN_SLT, 9, 8, 18, 0));
    emit(rtype(`MIPS_FN_SLTU, 9, 8, 19, 0));
    emit(itype(`MIPS_OP_SLTIU, 9, 20, -1));
    emit(itype(`MIPS_OP_ANDI, 9, 21, 16'hFF0F));
    emit(itype(`MIPS_OP_XORI, 8, 22, 16'hFFFF));
    emit(rtype(`MIPS_FN_ADDU, 13, 14, 2, 0));
    for (int r = 15; r <= 22; r++) begin
      emit(rtype((r % 2 == 0) ? `MIPS_FN_XOR : `MIPS_FN_ADDU, 2, r, 2, 0));
    end
    emit(rtype(`MIPS_FN_JR, 0, 0, 0, 0));
    emit(32'd0);
  endtask

  task automatic build_memory_program();
    prog_len = 0;
    emit(itype(`MIPS_OP_ADDIU, 0, 8, 16'h1000));
    emit(itype(`MIPS_OP_LUI, 0, 9, 16'h8765));
    emit(itype(`MIPS_OP_ORI, 9, 9, 16'h43A1));
    emit(itype(`MIPS_OP_SW, 8, 9, 0));
    emit(itype(`MIPS_OP_ADDIU, 0, 10, 16'h00B5));
    emit(itype(`MIPS_OP_SB, 8, 10, 5));
    emit(itype(`MIPS_OP_SB, 8, 9, 6));
    emit(itype(`MIPS_OP_SW, 8, 9, 8));
    emit(itype(`MIPS_OP_SB, 8, 0, 9));
    emit(itype(`MIPS_OP_LW, 8, 11, 4));
    emit(itype(`MIPS_OP_LB, 8, 12, 6));
    emit(itype(`MIPS_OP_LBU, 8, 13, 6));
    emit(itype(`MIPS_OP_LB, 8, 14, 1));
    emit(rtype(`MIPS_FN_ADDU, 11, 12, 2, 0));
    emit(rtype(`MIPS_FN_XOR, 2, 13, 2, 0));
    emit(rtype(`MIPS_FN_ADDU, 2, 14, 2, 0));
    emit(itype(`MIPS_OP_SW, 8, 2, 12));
    emit(rtype(`MIPS_FN_JR, 0, 0, 0, 0));
    emit(32'd0);
  endtask

  // slot numbers in the comments are branch targets
  task automatic build_branch_program();
    prog_len = 0;
    emit(itype(`MIPS_OP_ADDIU, 0, 2, 1));
    emit(itype(`MIPS_OP_ADDIU, 0, 8, 5));
    emit(itype(`MIPS_OP_BEQ, 8, 8, 3));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 10));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 100));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 100));
    // slot 6
    emit(itype(`MIPS_OP_BNE, 8, 0, 2));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 20));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 1000));
    // slot 9, not taken
    emit(itype(`MIPS_OP_BEQ, 8, 0, 5));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 3));
    emit(jtype(`MIPS_OP_JAL, slot_addr(15)));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 40));
    emit(jtype(`MIPS_OP_J, slot_addr(18)));
    emit(rtype(`MIPS_FN_XOR, 2, 31, 2, 0));
    // slot 15, subroutine
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 7));
    emit(rtype(`MIPS_FN_JR, 31, 0, 0, 0));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 50));
    // slot 18
    emit(rtype(`MIPS_FN_JR, 0, 0, 0, 0));
    emit(itype(`MIPS_OP_ADDIU, 2, 2, 1));
  endtask

  task automatic reset_and_load(input logic stalls);
    @(posedge clk);
    #1;
    reset = 1'b1;
    random_stalls = stalls;
    for (int i = 0; i < 256; i++) begin
      mem_i.code_mem[i] = (i < prog_len) ? prog[i] : 32'd0;
    end
    for (int i = 0; i < 64; i++) begin
      mem_i.data_mem[i] = fill_word(32'h1000 + 32'(i * 4));
    end
    repeat (4) begin
      @(posedge clk);
      #1;
      check_level(read, 1'b0, "read during reset");
      check_level(write, 1'b0, "write during reset");
    end
    reset = 1'b0;
  endtask

  task automatic wait_first_fetch();
    int cycles;
    cycles = 0;
    while (!read) begin
      if (cycles == 20) begin
        $display("timeout: no fetch issued after reset");
        $display("Simulation FAILED");
        $fatal(1);
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    check_level(active, 1'b1, "active after reset");
    check_word(address, `MIPS_RESET_VECTOR, "first fetch address");
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (active) begin
      if (cycles == 5000) begin
        $display("timeout: cpu never dropped active");
        $display("Simulation FAILED");
        $fatal(1);
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic run_program(input string name, input logic stalls);
    word_t exp_v0;
    word_t held_v0;
    exp_v0 = run_reference();
    reset_and_load(stalls);
    wait_first_fetch();
    wait_halt();
    check_word(register_v0, exp_v0, {name, " v0"});
    for (int i = 0; i < 64; i++) begin
      check_word(mem_i.data_mem[i], ref_data[i], {name, " data word"});
    end
    held_v0 = register_v0;
    // halted cpu stays off the bus
    repeat (20) begin
      @(posedge clk);
      #1;
      check_level(read, 1'b0, {name, " read after halt"});
      check_level(write, 1'b0, {name, " write after halt"});
      check_level(active, 1'b0, {name, " active after halt"});
      check_word(register_v0, held_v0, {name, " v0 after halt"});
    end
  endtask

  initial begin
    void'($urandom(37012));
    reset = 1'b1;
    random_stalls = 1'b0;
    prog_len = 0;
    build_alu_program();
    run_program("alu", 1'b0);
    build_memory_program();
    run_program("memory", 1'b0);
    zero_wait_v0 = register_v0;
    build_branch_program();
    run_program("branch", 1'b0);
    build_memory_program();
    run_program("memory stalled", 1'b1);
    check_word(register_v0, zero_wait_v0, "stalled v0 vs zero wait");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/avalon_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module avalon_mem_model import mips_pkg::*; (
  input  logic       clk,
  input  logic       random_stalls,
  input  word_t      address,
  input  logic       read,
  input  logic       write,
  input  word_t      writedata,
  input  logic [3:0] byteenable,
  output word_t      readdata,
  output logic       waitrequest
);

  // code window at the reset vector, data window at 0x1000
  word_t code_mem [256];
  word_t data_mem [64];

  logic code_hit;
  logic data_hit;

  assign code_hit = (address[31:10] == 22'(`MIPS_RESET_VECTOR >> 10));
  assign data_hit = (address[31:8] == 24'h000010);

  always_comb begin
    if (code_hit) begin
      readdata = code_mem[address[9:2]];
    end else if (data_hit) begin
      readdata = data_mem[address[7:2]];
    end else begin
      readdata = '0;
    end
  end

  // new stall decision each cycle, just after the edge
  initial waitrequest = 1'b0;
  always @(posedge clk) begin
    #1;
    waitrequest = random_stalls ? ($urandom_range(0, 2) == 0) : 1'b0;
  end

  // write lands per lane, little endian
  always @(posedge clk) begin
    if (write && !waitrequest && data_hit) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteenable[lane]) begin
          data_mem[address[7:2]][lane*8 +: 8] <= writedata[lane*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus import mips_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output logic       active,
  output word_t      register_v0,

  // avalon master
  output word_t      address,
  output logic       write,
  output logic       read,
  input  logic       waitrequest,
  output word_t      writedata,
  output logic [3:0] byteenable,
  input  word_t      readdata
);

  word_t      instr;
  ctrl_t      ctrl;
  cpu_state_t state;
  logic       pc_advance;
  logic       wb_enable;
  word_t      rs_value;
  word_t      rt_value;
  word_t      alu_result;
  logic       equal;
  word_t      pc;
  word_t      pc_plus8;
  word_t      next_pc;
  word_t      load_value;

  mips_control control_i (
    .clk          (clk),
    .reset        (reset),
    .waitrequest  (waitrequest),
    .readdata     (readdata),
    .next_pc_zero (next_pc == 32'd0),
    .instr        (instr),
    .ctrl         (ctrl),
    .state        (state),
    .read         (read),
    .write        (write),
    .active       (active),
    .pc_advance   (pc_advance),
    .wb_enable    (wb_enable)
  );

  mips_register_file register_file_i (
    .clk         (clk),
    .reset       (reset),
    .wb_enable   (wb_enable),
    .ctrl        (ctrl),
    .rs          (instr[25:21]),
    .rt          (instr[20:16]),
    .alu_result  (alu_result),
    .load_value  (load_value),
    .pc_plus8    (pc_plus8),
    .rs_value    (rs_value),
    .rt_value    (rt_value),
    .register_v0 (register_v0)
  );

  mips_alu alu_i (
    .ctrl       (ctrl),
    .rs_value   (rs_value),
    .rt_value   (rt_value),
    .imm        (instr[15:0]),
    .shamt      (instr[10:6]),
    .alu_result (alu_result),
    .equal      (equal)
  );

  mips_pc_unit pc_unit_i (
    .clk        (clk),
    .reset      (reset),
    .pc_advance (pc_advance),
    .ctrl       (ctrl),
    .equal      (equal),
    .imm        (instr[15:0]),
    .jump_index (instr[25:0]),
    .rs_value   (rs_value),
    .pc         (pc),
    .pc_plus8   (pc_plus8),
    .next_pc    (next_pc)
  );

  mips_load_store load_store_i (
    .state      (state),
    .ctrl       (ctrl),
    .pc         (pc),
    .alu_result (alu_result),
    .rt_value   (rt_value),
    .readdata   (readdata),
    .address    (address),
    .writedata  (writedata),
    .load_value (load_value),
    .byteenable (byteenable)
  );

endmodule

`default_nettype wire

// File: source/mips_load_store.sv
`timescale 1ns/1ps
`default_nettype none

module mips_load_store import mips_pkg::*; (
  input  cpu_state_t  state,
  input  ctrl_t       ctrl,
  input  word_t       pc,
  input  word_t       alu_result,
  input  word_t       rt_value,
  input  word_t       readdata,
  output word_t       address,
  output word_t       writedata,
  output word_t       load_value,
  output logic [3:0]  byteenable
);

  word_t      data_addr;
  logic [1:0] lane;
  logic [7:0] load_byte;
  logic       data_phase;

  assign data_phase = (state == MEM);
  assign data_addr  = {alu_result[31:2], 2'b00};
  assign lane       = alu_result[1:0];

  // fetch uses pc, memory phase the aligned data address
  assign address = data_phase ? data_addr : pc;

  always_comb begin
    if (data_phase && ctrl.byte_access) begin
      byteenable = 4'b0001 << lane;
    end else begin
      byteenable = 4'b1111;
    end
  end

  // SB puts the byte on every lane, byteenable picks one
  assign writedata = ctrl.byte_access ? {4{rt_value[7:0]}} : rt_value;

  // little endian byte pick
  always_comb begin
    case (lane)
      2'd0:    load_byte = readdata[7:0];
      2'd1:    load_byte = readdata[15:8];
      2'd2:    load_byte = readdata[23:16];
      default: load_byte = readdata[31:24];
    endcase
  end

  always_comb begin
    if (!ctrl.byte_access) begin
      load_value = readdata;
    end else if (ctrl.load_unsigned) begin
      load_value = {24'd0, load_byte};
    end else begin
      load_value = {{24{load_byte[7]}}, load_byte};
    end
  end

endmodule

`default_nettype wire

// File: source/mips_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module mips_pc_unit import mips_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        pc_advance,
  input  ctrl_t       ctrl,
  input  logic        equal,
  input  logic [15:0] imm,
  input  logic [25:0] jump_index,
  input  word_t       rs_value,
  output word_t       pc,
  output word_t       pc_plus8,
  output word_t       next_pc
);

  word_t pc_plus4;
  word_t branch_target;
  word_t jump_target;
  word_t target;
  word_t advance_pc;
  word_t delay_target;
  logic  pending;
  logic  taken;

  assign pc_plus4      = pc + 32'd4;
  assign pc_plus8      = pc + 32'd8;
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

  assign taken  = (ctrl.is_branch && (equal ^ ctrl.branch_ne)) ||
                  ctrl.is_jump || ctrl.is_jump_reg;
  assign target = ctrl.is_jump_reg ? rs_value :
                  (ctrl.is_jump ? jump_target : branch_target);

  // pending means the current instruction sits in a delay slot
  assign advance_pc = pending ? delay_target : pc_plus4;
  assign next_pc    = pc_advance ? advance_pc : pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= `MIPS_RESET_VECTOR;
      pending <= 1'b0;
    end else if (pc_advance) begin
      pc      <= advance_pc;
      pending <= taken;
    end
  end

  always_ff @(posedge clk) begin
    if (pc_advance && taken) begin
      delay_target <= target;
    end
  end

endmodule

`default_nettype wire

// File: source/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module mips_alu import mips_pkg::*; (
  input  ctrl_t       ctrl,
  input  word_t       rs_value,
  input  word_t       rt_value,
  input  logic [15:0] imm,
  input  shamt_t      shamt,
  output word_t       alu_result,
  output logic        equal
);

  word_t imm_ext;
  word_t op_b;

  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign op_b    = ctrl.use_imm ? imm_ext : rt_value;

  always_comb begin
    case (ctrl.alu_fn)
      `MIPS_ALU_ADD:  alu_result = rs_value + op_b;
      `MIPS_ALU_SUB:  alu_result = rs_value - op_b;
      `MIPS_ALU_AND:  alu_result = rs_value & op_b;
      `MIPS_ALU_OR:   alu_result = rs_value | op_b;
      `MIPS_ALU_XOR:  alu_result = rs_value ^ op_b;
      `MIPS_ALU_SLT:  alu_result = {31'd0, $signed(rs_value) < $signed(op_b)};
      `MIPS_ALU_SLTU: alu_result = {31'd0, rs_value < op_b};
      // shifts take rt and the shamt field
      `MIPS_ALU_SLL:  alu_result = rt_value << shamt;
      `MIPS_ALU_SRL:  alu_result = rt_value >> shamt;
      `MIPS_ALU_SRA:  alu_result = word_t'($signed(rt_value) >>> shamt);
      `MIPS_ALU_LUI:  alu_result = {imm, 16'h0000};
      default:        alu_result = rs_value + op_b;
    endcase
  end

  // branch compare, always on the registers
  assign equal = (rs_value == rt_value);

endmodule

`default_nettype wire

// File: source/mips_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module mips_register_file import mips_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     wb_enable,
  input  ctrl_t    ctrl,
  input  reg_idx_t rs,
  input  reg_idx_t rt,
  input  word_t    alu_result,
  input  word_t    load_value,
  input  word_t    pc_plus8,
  output word_t    rs_value,
  output word_t    rt_value,
  output word_t    register_v0
);

  word_t regs [32];
  word_t wb_data;

  // load data beats link address beats alu result
  assign wb_data = ctrl.load ? load_value : (ctrl.link ? pc_plus8 : alu_result);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_enable) begin
      regs[ctrl.dest] <= wb_data;
    end
  end

  // $zero reads as zero whatever was written
  assign rs_value    = (rs == 5'd0) ? '0 : regs[rs];
  assign rt_value    = (rt == 5'd0) ? '0 : regs[rt];
  assign register_v0 = regs[2];

endmodule

`default_nettype wire

// File: source/mips_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module mips_control import mips_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       waitrequest,
  input  word_t      readdata,
  input  logic       next_pc_zero,
  output word_t      instr,
  output ctrl_t      ctrl,
  output cpu_state_t state,
  output logic       read,
  output logic       write,
  output logic       active,
  output logic       pc_advance,
  output logic       wb_enable
);

  logic [5:0] opcode;
  logic [5:0] funct;
  logic       fetch_done;
  logic       mem_done;

  assign opcode     = instr[31:26];
  assign funct      = instr[5:0];
  assign fetch_done = (state == FETCH) && read && !waitrequest;
  assign mem_done   = (state == MEM) && (read || write) && !waitrequest;

  // bus strobes are registered so they stay low through reset
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= FETCH;
      read   <= 1'b0;
      write  <= 1'b0;
      active <= 1'b1;
    end else begin
      case (state)
        FETCH: begin
          // first cycle out of reset raises read
          if (!read) begin
            read <= 1'b1;
          end else if (!waitrequest) begin
            read  <= 1'b0;
            state <= EXEC;
          end
        end
        EXEC: begin
          if (ctrl.load || ctrl.store) begin
            state <= MEM;
            read  <= ctrl.load;
            write <= ctrl.store;
          end else if (next_pc_zero) begin
            state  <= HALTED;
            active <= 1'b0;
          end else begin
            state <= FETCH;
            read  <= 1'b1;
          end
        end
        MEM: begin
          if (mem_done) begin
            write <= 1'b0;
            if (next_pc_zero) begin
              state  <= HALTED;
              active <= 1'b0;
              read   <= 1'b0;
            end else begin
              state <= FETCH;
              read  <= 1'b1;
            end
          end
        end
        default: begin
          // halted, everything frozen
          state <= HALTED;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      instr <= readdata;
    end
  end

  assign pc_advance = (state == EXEC);
  // loads write back when the read completes
  assign wb_enable  = ctrl.reg_write &&
                      (((state == EXEC) && !ctrl.load) || (mem_done && ctrl.load));

  always_comb begin
    ctrl        = '0;
    ctrl.alu_fn = `MIPS_ALU_ADD;
    ctrl.dest   = instr[20:16];
    case (opcode)
      `MIPS_OP_SPECIAL: begin
        ctrl.dest      = instr[15:11];
        ctrl.reg_write = 1'b1;
        case (funct)
          `MIPS_FN_ADDU: ctrl.alu_fn = `MIPS_ALU_ADD;
          `MIPS_FN_SUBU: ctrl.alu_fn = `MIPS_ALU_SUB;
          `MIPS_FN_AND:  ctrl.alu_fn = `MIPS_ALU_AND;
          `MIPS_FN_OR:   ctrl.alu_fn = `MIPS_ALU_OR;
          `MIPS_FN_XOR:  ctrl.alu_fn = `MIPS_ALU_XOR;
          `MIPS_FN_SLT:  ctrl.alu_fn = `MIPS_ALU_SLT;
          `MIPS_FN_SLTU: ctrl.alu_fn = `MIPS_ALU_SLTU;
          `MIPS_FN_SLL:  ctrl.alu_fn = `MIPS_ALU_SLL;
          `MIPS_FN_SRL:  ctrl.alu_fn = `MIPS_ALU_SRL;
          `MIPS_FN_SRA:  ctrl.alu_fn = `MIPS_ALU_SRA;
          `MIPS_FN_JR: begin
            ctrl.reg_write   = 1'b0;
            ctrl.is_jump_reg = 1'b1;
          end
          // unsupported function, no-op
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      `MIPS_OP_ADDIU, `MIPS_OP_SLTIU: begin
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_fn    = (opcode == `MIPS_OP_SLTIU) ? `MIPS_ALU_SLTU : `MIPS_ALU_ADD;
      end
      `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI: begin
        ctrl.use_imm      = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.reg_write    = 1'b1;
        case (opcode)
          `MIPS_OP_ANDI: ctrl.alu_fn = `MIPS_ALU_AND;
          `MIPS_OP_ORI:  ctrl.alu_fn = `MIPS_ALU_OR;
          default:       ctrl.alu_fn = `MIPS_ALU_XOR;
        endcase
      end
      `MIPS_OP_LUI: begin
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_fn    = `MIPS_ALU_LUI;
      end
      `MIPS_OP_LW, `MIPS_OP_LB, `MIPS_OP_LBU: begin
        ctrl.use_imm       = 1'b1;
        ctrl.reg_write     = 1'b1;
        ctrl.load          = 1'b1;
        ctrl.byte_access   = (opcode != `MIPS_OP_LW);
        ctrl.load_unsigned = (opcode == `MIPS_OP_LBU);
      end
      `MIPS_OP_SW, `MIPS_OP_SB: begin
        ctrl.use_imm     = 1'b1;
        ctrl.store       = 1'b1;
        ctrl.byte_access = (opcode == `MIPS_OP_SB);
      end
      `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = (opcode == `MIPS_OP_BNE);
      end
      `MIPS_OP_J: ctrl.is_jump = 1'b1;
      `MIPS_OP_JAL: begin
        ctrl.is_jump   = 1'b1;
        ctrl.link      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dest      = 5'd31;
      end
      default: ctrl.reg_write = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [4:0] shamt_t;
  typedef logic [3:0] alu_fn_t;

  typedef enum logic [1:0] {
    FETCH  = 2'd0,
    EXEC   = 2'd1,
    MEM    = 2'd2,
    HALTED = 2'd3
  } cpu_state_t;

  // decoded controls for the instruction in the instruction register
  typedef struct packed {
    alu_fn_t  alu_fn;
    logic     use_imm;
    logic     imm_zero_ext;
    logic     reg_write;
    reg_idx_t dest;
    // memory access
    logic     load;
    logic     store;
    logic     byte_access;
    logic     load_unsigned;
    // write pc+8 instead of alu result
    logic     link;
    // control flow
    logic     branch_ne;
    logic     is_branch;
    logic     is_jump;
    logic     is_jump_reg;
  } ctrl_t;

endpackage

`default_nettype wire

// File: source/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// first fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTIU   6'h0B
`define MIPS_OP_ANDI    6'h0C
`define MIPS_OP_ORI     6'h0D
`define MIPS_OP_XORI    6'h0E
`define MIPS_OP_LUI     6'h0F
`define MIPS_OP_LB      6'h20
`define MIPS_OP_LW      6'h23
`define MIPS_OP_LBU     6'h24
`define MIPS_OP_SB      6'h28
`define MIPS_OP_SW      6'h2B

// function field, SPECIAL only
`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_SRA  6'h03
`define MIPS_FN_JR   6'h08
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26
`define MIPS_FN_SLT  6'h2A
`define MIPS_FN_SLTU 6'h2B

// alu function select
`define MIPS_ALU_ADD  4'd0
`define MIPS_ALU_SUB  4'd1
`define MIPS_ALU_AND  4'd2
`define MIPS_ALU_OR   4'd3
`define MIPS_ALU_XOR  4'd4
`define MIPS_ALU_SLT  4'd5
`define MIPS_ALU_SLTU 4'd6
`define MIPS_ALU_SLL  4'd7
`define MIPS_ALU_SRL  4'd8
`define MIPS_ALU_SRA  4'd9
`define MIPS_ALU_LUI  4'd10

`endif
